/* src/sdram_pkg.sv */
/* sdram controller shared definitions
   command encodings, frame slots, timing, mode word and byte address fields */

`default_nettype none

package sdram_pkg;

	// --------------------
	// timing in clocks
	localparam int RASCAS_DELAY = 2;	// tRCD, ACTIVE to READ/WRITE
	localparam int CAS_LATENCY  = 2;	// READ to first data

	// --------------------
	// sdram commands, bit pattern is {cs, ras, cas, we}
	typedef enum logic [3:0] {
		INHIBIT         = 4'b1111,	// chip deselected
		NOP             = 4'b0111,
		ACTIVE          = 4'b0011,	// open row
		READ            = 4'b0101,
		WRITE           = 4'b0100,
		BURST_TERMINATE = 4'b0110,
		PRECHARGE       = 4'b0010,	// close row, all banks with A10
		AUTO_REFRESH    = 4'b0001,
		LOAD_MODE       = 4'b0000	// mode word on the address bus
	} sdram_cmd_e;

	// --------------------
	// named slots of the 8-clock frame, unnamed slots pass without action
	typedef enum logic [2:0] {
		SLOT_IDLE      = 3'd0,	// command for slot 1 chosen here
		SLOT_CMD_START = 3'd1,	// ACTIVE or AUTO_REFRESH on the pins
		SLOT_CMD_CONT  = 3'(1 + RASCAS_DELAY),	// READ/WRITE chosen here
		SLOT_CAPTURE   = 3'(2 + RASCAS_DELAY + CAS_LATENCY),	// read data on dq_in
		SLOT_LAST      = 3'd7	// waits here for clkref high
	} slot_e;

	// mode register
	// A12..A10 reserved, A9 single write, A8..A7 standard op,
	// A6..A4 cas latency, A3 sequential, A2..A0 no burst
	localparam logic [12:0] MODE_WORD = {3'b000, 1'b1, 2'b00, 3'(CAS_LATENCY), 1'b0, 3'b000};

	// --------------------
	// init countdown, in frames
	localparam int INIT_FRAMES       = 32;
	localparam int INIT_PRECHARGE_AT = 13;	// precharge all banks
	localparam int INIT_LOAD_MODE_AT = 2;	// then program the mode word

	// byte address fields, bit 0 picks the byte lane
	localparam int ADDR_W  = 25;
	localparam int ROW_LO  = 10;
	localparam int ROW_W   = 13;
	localparam int COL_LO  = 1;
	localparam int COL_W   = 9;
	localparam int BANK_LO = 23;	// two bank bits at the top

	localparam int AUTO_PRECHARGE_BIT = 10;	// A10

endpackage

`default_nettype wire

/* src/sdram_slot_counter.sv */
/* frame slot counter
   runs 8-clock frames and holds them in phase with the clkref reference clock */

`timescale 1ns/1ps
`default_nettype none

module sdram_slot_counter (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              clkref,	// clk / 8
	output sdram_pkg::slot_e       slot,
	output logic                   frame_end	// high during the last slot
);

	logic advance;	// move on to the next slot this clock

	// --------------------
	// lock to clkref
	// slot 6 is left only while clkref is low and slot 7 only while it is high,
	// so slot 0 always starts right after the rising edge of clkref.
	// a misaligned frame stretches in 6 or 7 until the phase is right
	always_comb begin
		case (slot)
			sdram_pkg::SLOT_CAPTURE: advance = !clkref;
			sdram_pkg::SLOT_LAST:    advance = clkref;
			default:                 advance = 1'b1;	// all other slots last one clock
		endcase
	end

	// --------------------
	// counter, wraps 7 -> 0
	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= sdram_pkg::SLOT_IDLE;
		end else if (advance) begin
			slot <= sdram_pkg::slot_e'(slot + 3'd1);	// unnamed slots 2, 4, 5 included
		end
	end

	assign frame_end = (slot == sdram_pkg::SLOT_LAST);

endmodule

`default_nettype wire

/* src/sdram_init_seq.sv */
/* sdram power-up sequencer
   counts 32 frames and issues precharge-all and load-mode on the way, then raises ready */

`timescale 1ns/1ps
`default_nettype none

module sdram_init_seq (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 frame_end,
	input  sdram_pkg::slot_e          slot,
	output sdram_pkg::sdram_cmd_e     init_cmd,	// picked up by the command generator
	output logic [12:0]               init_addr,
	output logic                      ready	// init done, stays high
);

	localparam int CNT_W = $clog2(sdram_pkg::INIT_FRAMES);

	logic [CNT_W-1:0] count;	// frames left
	logic             frame_end_q;
	logic             frame_tick;	// once per frame, first clock of slot 7

	// slot 7 may stretch while locking, count only its first clock
	assign frame_tick = frame_end && !frame_end_q;

	// --------------------
	// countdown
	always_ff @(posedge clk) begin
		if (reset) begin
			count       <= CNT_W'(sdram_pkg::INIT_FRAMES - 1);	// 31
			frame_end_q <= 1'b0;
			ready       <= 1'b0;
		end else begin
			frame_end_q <= frame_end;
			if (frame_tick) begin
				if (count != '0)
					count <= count - 1'b1;
				else
					ready <= 1'b1;	// last init frame is over
			end
		end
	end

	// --------------------
	// init commands, only in slot 0 of the chosen frames
	always_comb begin
		init_cmd  = sdram_pkg::INHIBIT;
		init_addr = '0;
		if (slot == sdram_pkg::SLOT_IDLE) begin
			if (count == CNT_W'(sdram_pkg::INIT_PRECHARGE_AT)) begin
				init_cmd  = sdram_pkg::PRECHARGE;
				init_addr = 13'd1 << sdram_pkg::AUTO_PRECHARGE_BIT;	// all banks
			end else if (count == CNT_W'(sdram_pkg::INIT_LOAD_MODE_AT)) begin
				init_cmd  = sdram_pkg::LOAD_MODE;
				init_addr = sdram_pkg::MODE_WORD;
			end
		end
	end

endmodule

`default_nettype wire

/* src/sdram_cmd_gen.sv */
/* sdram command generator
   latches a cpu request and issues ACTIVE and READ/WRITE, AUTO_REFRESH or init commands per slot */

`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_gen (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic                            req,	// one-clock strobe
	input  wire logic                            req_we,
	input  wire logic                            ready,
	input  wire logic [sdram_pkg::ADDR_W-1:0]    req_addr,	// byte address
	input  sdram_pkg::slot_e                     slot,
	input  sdram_pkg::sdram_cmd_e                init_cmd,
	input  wire logic [12:0]                     init_addr,
	output sdram_pkg::sdram_cmd_e                sd_cmd,
	output logic [12:0]                          sd_addr,
	output logic [1:0]                           sd_ba,
	output logic                                 acc_start,	// READ/WRITE on the pins
	output logic                                 acc_we,
	output logic                                 acc_lane	// 1 = upper byte
);

	// --------------------
	// request latch
	logic                         pend;	// accepted, READ/WRITE not issued yet
	logic                         pend_we;
	logic [sdram_pkg::ADDR_W-1:0] pend_addr;
	logic                         take;	// strobe accepted
	logic                         acc_frame;	// current frame carries the access
	logic                         issue;	// READ/WRITE chosen this clock

	logic [12:0] row_addr;
	logic [12:0] col_word;	// column with auto precharge
	logic [1:0]  bank;

	sdram_pkg::sdram_cmd_e cmd_nxt;
	logic [12:0]           addr_nxt;
	logic [1:0]            ba_nxt;

	assign take  = req && ready && !pend;	// strobes while busy are dropped
	assign issue = (slot == sdram_pkg::SLOT_CMD_CONT) && acc_frame;

	always_ff @(posedge clk) begin
		if (reset) begin
			pend      <= 1'b0;
			acc_frame <= 1'b0;
		end else begin
			if (take)
				pend <= 1'b1;
			else if (issue)
				pend <= 1'b0;	// free again once the column command goes out

			// frame decision is made in slot 0 only
			if (slot == sdram_pkg::SLOT_IDLE)
				acc_frame <= pend && ready;
			else if (slot == sdram_pkg::SLOT_CMD_CONT)
				acc_frame <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend_we   <= req_we;
			pend_addr <= req_addr;
		end
	end

	// --------------------
	// address split
	assign row_addr = pend_addr[sdram_pkg::ROW_LO +: sdram_pkg::ROW_W];
	assign bank     = pend_addr[sdram_pkg::BANK_LO +: 2];

	always_comb begin
		col_word = '0;
		col_word[sdram_pkg::COL_W-1:0] = pend_addr[sdram_pkg::COL_LO +: sdram_pkg::COL_W];
		col_word[sdram_pkg::AUTO_PRECHARGE_BIT] = 1'b1;	// close the row after the access
	end

	// --------------------
	// next command, on the pins one slot later
	always_comb begin
		cmd_nxt  = sdram_pkg::INHIBIT;
		addr_nxt = '0;
		ba_nxt   = '0;
		if (!ready) begin
			cmd_nxt  = init_cmd;	// INHIBIT outside the two init frames
			addr_nxt = init_addr;
		end else if (slot == sdram_pkg::SLOT_IDLE) begin
			if (pend) begin
				cmd_nxt  = sdram_pkg::ACTIVE;
				addr_nxt = row_addr;
				ba_nxt   = bank;
			end else begin
				cmd_nxt = sdram_pkg::AUTO_REFRESH;	// idle frame
			end
		end else if (issue) begin
			cmd_nxt  = pend_we ? sdram_pkg::WRITE : sdram_pkg::READ;
			addr_nxt = col_word;
			ba_nxt   = bank;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sd_cmd    <= sdram_pkg::INHIBIT;
			acc_start <= 1'b0;
		end else begin
			sd_cmd    <= cmd_nxt;
			acc_start <= issue;	// lines up with READ/WRITE on the pins
		end
	end

	// pin address and access info
	always_ff @(posedge clk) begin
		sd_addr <= addr_nxt;
		sd_ba   <= ba_nxt;
		if (issue) begin
			acc_we   <= pend_we;
			acc_lane <= pend_addr[0];
		end
	end

endmodule

`default_nettype wire

/* src/sdram_data_path.sv */
/* sdram data path
   drives write data and byte masks, captures the read lane and signals done */

`timescale 1ns/1ps
`default_nettype none

module sdram_data_path (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          req,	// loads the write byte
	input  wire logic          acc_start,	// slot 4 of an access frame
	input  wire logic          acc_we,
	input  wire logic          acc_lane,
	input  sdram_pkg::slot_e   slot,
	input  wire logic [7:0]    req_din,
	input  wire logic [15:0]   dq_in,
	output logic [15:0]        dq_out,
	output logic               dq_oe,
	output logic [1:0]         sd_dqm,	// {udqm, ldqm}
	output logic               done,
	output logic [7:0]         dout
);

	logic [7:0] wr_byte;
	logic       wr_done;	// write finished, high in slot 5
	logic       rd_pend;	// read issued, waiting for the capture slot
	logic       rd_lane;
	logic [7:0] rd_byte;

	// --------------------
	// write side
	always_ff @(posedge clk) begin
		if (req)
			wr_byte <= req_din;	// held until the WRITE slot
	end

	assign dq_oe  = acc_start && acc_we;	// only during the WRITE command
	assign dq_out = {wr_byte, wr_byte};	// same byte on both lanes
	// mask the lane that is not addressed
	assign sd_dqm = dq_oe ? (acc_lane ? 2'b01 : 2'b10) : 2'b00;

	// --------------------
	// read side
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_done <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			wr_done <= acc_start && acc_we;
			if (acc_start && !acc_we)
				rd_pend <= 1'b1;
			else if (slot == sdram_pkg::SLOT_LAST)
				rd_pend <= 1'b0;	// done was given this clock
		end
	end

	always_ff @(posedge clk) begin
		if (acc_start)
			rd_lane <= acc_lane;
		// cas latency 2 puts the data here, last clock of slot 6 wins
		if (rd_pend && slot == sdram_pkg::SLOT_CAPTURE)
			rd_byte <= rd_lane ? dq_in[15:8] : dq_in[7:0];
	end

	assign done = wr_done || (rd_pend && slot == sdram_pkg::SLOT_LAST);
	assign dout = rd_byte;	// valid with done for reads

endmodule

`default_nettype wire

/* src/sdram_ctrl_top.sv */
/* single-port sdram controller, top level
   joins slot counter, init sequencer, command generator and data path to the pins */

`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top (
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic                           clkref,	// frame reference, clk / 8

	// cpu side
	input  wire logic                           req,
	input  wire logic                           req_we,
	input  wire logic [sdram_pkg::ADDR_W-1:0]   req_addr,
	input  wire logic [7:0]                     req_din,
	output logic                                done,
	output logic [7:0]                          dout,
	output logic                                ready,

	// sdram pins, dq split into out, enable and in
	output sdram_pkg::sdram_cmd_e               sd_cmd,	// {cs, ras, cas, we}
	output logic [12:0]                         sd_addr,
	output logic [1:0]                          sd_ba,
	output logic [1:0]                          sd_dqm,
	output logic [15:0]                         dq_out,
	output logic                                dq_oe,
	input  wire logic [15:0]                    dq_in
);

	sdram_pkg::slot_e      slot;
	logic                  frame_end;
	sdram_pkg::sdram_cmd_e init_cmd;
	logic [12:0]           init_addr;
	logic                  acc_start;
	logic                  acc_we;
	logic                  acc_lane;

	// --------------------
	// frame timing
	sdram_slot_counter i_slot_counter (
		.clk       (clk),
		.reset     (reset),
		.clkref    (clkref),
		.slot      (slot),
		.frame_end (frame_end)
	);

	sdram_init_seq i_init_seq (
		.clk       (clk),
		.reset     (reset),
		.frame_end (frame_end),
		.slot      (slot),
		.init_cmd  (init_cmd),
		.init_addr (init_addr),
		.ready     (ready)
	);

	// --------------------
	// command and data
	sdram_cmd_gen i_cmd_gen (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.req_we    (req_we),
		.ready     (ready),
		.req_addr  (req_addr),
		.slot      (slot),
		.init_cmd  (init_cmd),
		.init_addr (init_addr),
		.sd_cmd    (sd_cmd),
		.sd_addr   (sd_addr),
		.sd_ba     (sd_ba),
		.acc_start (acc_start),
		.acc_we    (acc_we),
		.acc_lane  (acc_lane)
	);

	sdram_data_path i_data_path (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.acc_start (acc_start),
		.acc_we    (acc_we),
		.acc_lane  (acc_lane),
		.slot      (slot),
		.req_din   (req_din),
		.dq_in     (dq_in),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.sd_dqm    (sd_dqm),
		.done      (done),
		.dout      (dout)
	);

endmodule

`default_nettype wire

/* test/sdram_chip_model.sv */
/* behavioral sdram model
   open row per bank, cas latency 2 read pipe, sparse word storage by bank, row and column */

`timescale 1ns/1ps
`default_nettype none

module sdram_chip_model (
	input  wire logic                    clk,
	input  sdram_pkg::sdram_cmd_e        sd_cmd,
	input  wire logic [12:0]             sd_addr,
	input  wire logic [1:0]              sd_ba,
	input  wire logic [1:0]              sd_dqm,	// {udqm, ldqm}, 1 masks the lane
	input  wire logic [15:0]             dq_out,
	input  wire logic                    dq_oe,
	output logic [15:0]                  dq_in
);

	logic [15:0] mem [logic [23:0]];	// key {bank, row, col}
	logic [12:0] open_row [4];
	logic [15:0] rd_pipe;	// first stage of the read pipe

	// words never written read back a pattern built from the full key
	function automatic logic [15:0] fill_word(input logic [23:0] key);
		return {key[23:16] ^ key[7:0], key[15:8] ^ 8'h5a};
	endfunction

	initial begin
		dq_in   = '0;
		rd_pipe = '0;
	end

	always @(posedge clk) begin : model_step
		logic [23:0] key;
		logic [15:0] word;
		key  = {sd_ba, open_row[sd_ba], sd_addr[8:0]};
		word = mem.exists(key) ? mem[key] : fill_word(key);
		case (sd_cmd)
			sdram_pkg::ACTIVE: open_row[sd_ba] <= sd_addr;	// row opened
			sdram_pkg::WRITE: begin
				if (dq_oe && !sd_dqm[0])
					word[7:0] = dq_out[7:0];
				if (dq_oe && !sd_dqm[1])
					word[15:8] = dq_out[15:8];
				mem[key] = word;
			end
			sdram_pkg::READ: rd_pipe <= word;	// data on dq_in two clocks later
			default: ;
		endcase
		dq_in <= rd_pipe;	// second stage, held until the next read
	end

endmodule

`default_nettype wire

/* test/sdram_ctrl_chk.sv */
/* controller protocol checker
   bound to the top level, watches command spacing and the request handshake */

`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_chk (
	input wire logic               clk,
	input wire logic               reset,
	input sdram_pkg::sdram_cmd_e   sd_cmd,
	input wire logic               req,
	input wire logic               done,
	input wire logic               acc_start,
	input wire logic               pend	// request latched in the command generator
);

	int open_acc;	// accesses issued without done yet

	always_ff @(posedge clk) begin
		if (reset)
			open_acc <= 0;
		else
			open_acc <= open_acc + int'(acc_start) - int'(done);
	end

	// column command exactly tRCD + 1 slots after ACTIVE
	a_col_after_act: assert property (@(posedge clk) disable iff (reset)
		(sd_cmd == sdram_pkg::READ || sd_cmd == sdram_pkg::WRITE)
		|-> $past(sd_cmd, 3) == sdram_pkg::ACTIVE)
		else $error("column command without ACTIVE three clocks before");

	a_done_has_acc: assert property (@(posedge clk) disable iff (reset)
		done |-> open_acc != 0)
		else $error("done without an issued access");

	a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
		req |-> !pend)
		else $error("req while a request is pending");

endmodule

bind sdram_ctrl_top sdram_ctrl_chk i_ctrl_chk (
	.clk       (clk),
	.reset     (reset),
	.sd_cmd    (sd_cmd),
	.req       (req),
	.done      (done),
	.acc_start (i_cmd_gen.acc_start),
	.pend      (i_cmd_gen.pend)
);

`default_nettype wire

/* test/tb_sdram_ctrl.sv */
/* testbench for the sdram controller
   runs the stimulus file against the controller and the chip model, checks pins and data */

`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;

	logic clk = 1'b0;
	logic reset;
	logic [2:0] ref_cnt = '0;	// clkref phase
	logic clkref;
	logic req, req_we, done, ready, dq_oe;
	logic [24:0] req_addr;
	logic [7:0] req_din, dout;
	logic [12:0] sd_addr;
	logic [1:0] sd_ba, sd_dqm;
	logic [15:0] dq_out, dq_in;
	sdram_pkg::sdram_cmd_e sd_cmd;

	byte ops[$];
	logic [24:0] addrs[$];
	logic [7:0] wdats[$], exps[$];
	int limit = 0;
	int cycles = 0;
	int refresh_cnt = 0, done_cnt = 0, precharges = 0, loads = 0;
	logic verdict_given = 1'b0;	// pass or fail already printed

	always #4 clk = ~clk;	// 8 ns period
	always @(posedge clk) ref_cnt <= ref_cnt + 3'd1;
	assign clkref = ref_cnt[2];	// rises when ref_cnt becomes 4

	sdram_ctrl_top i_sdram_ctrl_top (.*);
	sdram_chip_model i_chip (.*);

	task automatic stop_with_failure(input string msg);
		verdict_given = 1'b1;
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_e got,
			input sdram_pkg::sdram_cmd_e exp);
		if (got !== exp)
			stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [12:0] got, input logic [12:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	// reads all lines first so the timeout can be sized
	task automatic load_stimulus();
		int fd;
		int idle;
		string line;
		byte op;
		logic [24:0] a;
		logic [7:0] w, e;
		idle = 0;
		fd = $fopen("test/sdram_stimulus.txt", "r");
		if (fd == 0)
			stop_with_failure("could not open the stimulus file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			if ($sscanf(line, "%c %h %h %h", op, a, w, e) != 4)
				stop_with_failure({"malformed stimulus line: ", line});
			ops.push_back(op);
			addrs.push_back(a);
			wdats.push_back(w);
			exps.push_back(e);
			if (op == "I")
				idle += int'(a);
		end
		$fclose(fd);
		limit = (40 + 3 * ops.size() + idle) * 8;
	endtask

	task automatic run_access(input logic we, input logic [24:0] a, input logic [7:0] w,
			input logic [7:0] e);
		@(posedge clk);
		req      <= 1'b1;
		req_we   <= we;
		req_addr <= a;
		req_din  <= w;
		@(posedge clk);
		req <= 1'b0;
		while (!done)
			@(posedge clk);
		if (!we)
			check_byte("dout", dout, e);
	endtask

	// --------------------
	// pin monitor
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit)
			stop_with_failure("timeout, the run took longer than the stimulus allows");
		if (!reset && !ready) begin
			case (sd_cmd)
				sdram_pkg::PRECHARGE: begin
					if (precharges != 0 || loads != 0)
						stop_with_failure("extra precharge during init");
					check_word("sd_addr", sd_addr, 13'h0400);	// A10, all banks
					precharges <= precharges + 1;
				end
				sdram_pkg::LOAD_MODE: begin
					if (precharges != 1 || loads != 0)
						stop_with_failure("load mode out of order during init");
					// A9 single write, A6..A4 cas latency 2, no burst
					check_word("sd_addr", sd_addr, 13'h0220);
					loads <= loads + 1;
				end
				default: check_cmd("sd_cmd", sd_cmd, sdram_pkg::INHIBIT);
			endcase
		end
		if (!reset && ready) begin
			// slot 1 of a locked frame falls on ref_cnt 6
			if ((sd_cmd == sdram_pkg::ACTIVE || sd_cmd == sdram_pkg::AUTO_REFRESH)
					&& ref_cnt != 3'd6)
				stop_with_failure("row or refresh command out of phase with clkref");
			if (sd_cmd == sdram_pkg::AUTO_REFRESH)
				refresh_cnt <= refresh_cnt + 1;
		end
		if (!reset && done)
			done_cnt <= done_cnt + 1;
	end

	// --------------------
	// main sequence
	initial begin : main_seq
		int k;
		int snap;
		int accepted;
		req      = 1'b0;
		req_we   = 1'b0;
		req_addr = '0;
		req_din  = '0;
		reset    = 1'b1;
		accepted = 0;
		load_stimulus();
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		k = 0;
		while (!ready) begin
			@(posedge clk);
			k++;
		end
		// 32 frames plus up to one frame of lock-in
		if (k < sdram_pkg::INIT_FRAMES * 8 - 1 || k > sdram_pkg::INIT_FRAMES * 8 + 9)
			stop_with_failure($sformatf("ready rose after %0d cycles", k));
		check_count("precharges", precharges, 1);
		check_count("loads", loads, 1);

		foreach (ops[i]) begin
			if (ops[i] == "I") begin
				snap = refresh_cnt;
				repeat (int'(addrs[i]) * 8) @(posedge clk);
				check_count("refresh_cnt", refresh_cnt - snap, int'(addrs[i]));
			end else begin
				run_access(ops[i] == "W", addrs[i], wdats[i], exps[i]);
				accepted++;
			end
		end

		repeat (8) @(posedge clk);
		check_count("done_cnt", done_cnt, accepted);
		verdict_given = 1'b1;
		$display("TEST RESULT: PASS");
		$finish;
	end

	final begin
		if (!verdict_given)
			$display("TEST RESULT: FAIL");
	end

endmodule

`default_nettype wire

/* build.f */
src/sdram_pkg.sv
src/sdram_slot_counter.sv
src/sdram_init_seq.sv
src/sdram_cmd_gen.sv
src/sdram_data_path.sv
src/sdram_ctrl_top.sv
test/sdram_chip_model.sv
test/sdram_ctrl_chk.sv
test/tb_sdram_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# compile the sdram controller testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wall -j 0 -f build.f --top-module tb_sdram_ctrl -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	exit 1
fi
exit 0

/* test/sdram_stimulus.txt */
# op addr(hex) wdata(hex) expect(hex)
# W write, R read and compare, I idle frames given in the addr column
I 0000003 00 00
W 0000100 a5 00
R 0000100 00 a5
W 0000200 3c 00
W 0000201 c3 00
R 0000200 00 3c
R 0000201 00 c3
W 0000400 11 00
W 0800400 22 00
W 0000800 33 00
W 0000402 44 00
R 0000400 00 11
R 0800400 00 22
R 0000800 00 33
R 0000402 00 44
I 0000005 00 00
W 1ffffff e7 00
R 1ffffff 00 e7
R 0000201 00 c3
I 0000002 00 00
